// File: hdl/stream_defs.svh
// ##############################
// stream definitions
// widths and depth for the capture path
// ##############################

`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// one input sample
`define SAMPLE_W 16

// two samples packed side by side
`define WORD_W 32

// 512 lines of block RAM
`define FIFO_AW 9

// space and occupied diagnostics
`define CNT_W 16

`endif

// File: hdl/stream_pkg.sv
// ##############################
// stream types
// beats, result record and FIFO read states
// ##############################

`include "stream_defs.svh"

package stream_pkg;

   typedef logic [`SAMPLE_W-1:0] sample_t;
   typedef logic [`WORD_W-1:0]   word_t;
   typedef logic [`CNT_W-1:0]    fifo_cnt_t;

   // one sample on the input stream
   typedef struct packed {
      logic    frame_end;
      sample_t data;
   } sample_beat_t;

   // one packed word, as stored in the FIFO
   typedef struct packed {
      logic  frame_end;
      word_t data;
   } word_beat_t;

   // per-frame totals
   typedef struct packed {
      fifo_cnt_t count;
      word_t     sum;
   } frame_result_t;

   typedef enum logic [1:0] {
      ST_EMPTY,
      PRE_READ,
      READING
   } read_state_t;

endpackage

// File: hdl/dpram.sv
// ##############################
// dual-port block RAM
// one write port, one registered read port
// ##############################

`timescale 1ns/10ps

module dpram
#(
   parameter int WIDTH = 32,
   parameter int SIZE  = 9
)
(
   input  logic             clk,
   input  logic             i_write_enable,
   input  logic [SIZE-1:0]  i_write_address,
   input  logic [WIDTH-1:0] i_write_data,
   input  logic             i_read_enable,
   input  logic [SIZE-1:0]  i_read_address,
   output logic [WIDTH-1:0] o_read_data
);

   localparam int LINES = 2 ** SIZE;

   logic [WIDTH-1:0] mem [0:LINES-1];

   always_ff @(posedge clk)
   begin
      if (i_write_enable)
      begin
         mem[i_write_address] <= i_write_data;
      end
   end

   // read register holds its value while the enable is low
   always_ff @(posedge clk)
   begin
      if (i_read_enable)
      begin
         o_read_data <= mem[i_read_address];
      end
   end

endmodule

// File: hdl/axi_fifo_bram.sv
// ##############################
// block RAM stream FIFO
// read-ahead into an output register
// ##############################

`timescale 1ns/10ps

module axi_fifo_bram
   import stream_pkg::*;
#(
   parameter int WIDTH = $bits(word_beat_t),
   parameter int SIZE  = 9
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       i_clear,
   input  word_beat_t i_data,
   input  logic       i_valid,
   output logic       o_ready,
   output word_beat_t o_data,
   output logic       o_valid,
   input  logic       i_ready,
   output fifo_cnt_t  o_space,
   output fifo_cnt_t  o_occupied
);

   localparam fifo_cnt_t NUMLINES = fifo_cnt_t'(2 ** SIZE);

   logic [SIZE-1:0]  wr_addr;
   logic [SIZE-1:0]  rd_addr;
   logic [SIZE-1:0]  full_mark;
   logic [WIDTH-1:0] int_data;
   read_state_t      read_state;
   logic             empty_reg;
   logic             full_reg;
   logic             int_ready;
   logic             write;
   logic             read_int;
   logic             read;
   logic             ram_read_en;
   logic             becoming_full;

   if (WIDTH != $bits(word_beat_t))
   begin : g_width_check
      $error("axi_fifo_bram: WIDTH must equal the word beat width");
   end

   // outer port transfers
   assign write = i_valid & o_ready;
   assign read  = o_valid & i_ready;

   // output register can take a new word
   assign int_ready = i_ready | ~o_valid;

   // RAM output moves into the output register
   assign read_int = ~empty_reg & int_ready;

   assign o_ready     = ~full_reg;
   assign ram_read_en = (read_state == PRE_READ) | read_int;

   // full once the write pointer lands two behind the read pointer
   assign full_mark     = rd_addr - SIZE'(3);
   assign becoming_full = (wr_addr == full_mark);

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         wr_addr <= '0;
      end
      else if (write)
      begin
         wr_addr <= wr_addr + 1'b1;
      end
   end

   dpram #(
      .WIDTH (WIDTH),
      .SIZE  (SIZE)
   ) ram (
      .clk             (clk),
      .i_write_enable  (write),
      .i_write_address (wr_addr),
      .i_write_data    (i_data),
      .i_read_enable   (ram_read_en),
      .i_read_address  (rd_addr),
      .o_read_data     (int_data)
   );

   // read side keeps the next word fetched ahead of the request
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         read_state <= ST_EMPTY;
         rd_addr    <= '0;
         empty_reg  <= 1'b1;
      end
      else
      begin
         case (read_state)
            ST_EMPTY:
            begin
               if (write)
               begin
                  read_state <= PRE_READ;
               end
            end
            PRE_READ:
            begin
               // RAM read issued this cycle
               read_state <= READING;
               empty_reg  <= 1'b0;
               rd_addr    <= rd_addr + 1'b1;
            end
            READING:
            begin
               if (read_int)
               begin
                  if (rd_addr == wr_addr)
                  begin
                     // last stored word just left the RAM
                     empty_reg  <= 1'b1;
                     read_state <= write ? PRE_READ : ST_EMPTY;
                  end
                  else
                  begin
                     rd_addr <= rd_addr + 1'b1;
                  end
               end
            end
            default:
            begin
               read_state <= ST_EMPTY;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         full_reg <= 1'b0;
      end
      else if (read_int && !write)
      begin
         full_reg <= 1'b0;
      end
      else if (write && !read_int && becoming_full)
      begin
         full_reg <= 1'b1;
      end
   end

   // output stage
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_valid <= 1'b0;
      end
      else if (int_ready)
      begin
         o_valid <= ~empty_reg;
      end
   end

   always_ff @(posedge clk)
   begin
      if (int_ready)
      begin
         o_data <= word_beat_t'(int_data);
      end
   end

   // diagnostics, counted on outer port transfers
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_space    <= NUMLINES;
         o_occupied <= '0;
      end
      else if (read && !write)
      begin
         o_space    <= o_space + 1'b1;
         o_occupied <= o_occupied - 1'b1;
      end
      else if (write && !read)
      begin
         o_space    <= o_space - 1'b1;
         o_occupied <= o_occupied + 1'b1;
      end
   end

   // a write never lands in a FIFO that already counts every line
   a_no_write_full: assert property (@(posedge clk) disable iff (reset || i_clear)
      write |-> o_occupied < NUMLINES);

   a_out_stable: assert property (@(posedge clk) disable iff (reset || i_clear)
      o_valid && !i_ready |=> o_valid && $stable(o_data));

   a_occupied_max: assert property (@(posedge clk) disable iff (reset)
      o_occupied <= NUMLINES);

endmodule

// File: hdl/sample_packer.sv
// ##############################
// sample packer
// two samples into one word per beat
// ##############################

`timescale 1ns/10ps

`include "stream_defs.svh"

module sample_packer
   import stream_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         i_clear,
   input  sample_beat_t i_sample,
   input  logic         i_sample_valid,
   output logic         o_sample_ready,
   output word_beat_t   o_word,
   output logic         o_word_valid,
   input  logic         i_word_ready
);

   sample_t half_data;
   logic    half_valid;
   logic    take;
   logic    word_done;

   // accept only when the output register is free or draining
   assign o_sample_ready = ~o_word_valid | i_word_ready;
   assign take           = i_sample_valid & o_sample_ready;

   // second of a pair, or a frame ending on the first
   assign word_done = take & (half_valid | i_sample.frame_end);

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         half_valid <= 1'b0;
      end
      else if (take)
      begin
         // pairing restarts after every emitted word
         half_valid <= ~half_valid & ~i_sample.frame_end;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take && !half_valid)
      begin
         half_data <= i_sample.data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (word_done)
      begin
         o_word.frame_end <= i_sample.frame_end;
         if (half_valid)
         begin
            o_word.data <= {i_sample.data, half_data};
         end
         else
         begin
            // lone sample with the upper half zero
            o_word.data <= {{`SAMPLE_W{1'b0}}, i_sample.data};
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_word_valid <= 1'b0;
      end
      else if (word_done)
      begin
         o_word_valid <= 1'b1;
      end
      else if (i_word_ready)
      begin
         o_word_valid <= 1'b0;
      end
   end

   a_word_stable: assert property (@(posedge clk) disable iff (reset || i_clear)
      o_word_valid && !i_word_ready |=> o_word_valid && $stable(o_word));

endmodule

// File: hdl/frame_checksum.sv
// ##############################
// frame checksum
// word count and sum per frame
// ##############################

`timescale 1ns/10ps

module frame_checksum
   import stream_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          i_clear,
   input  word_beat_t    i_word,
   input  logic          i_word_valid,
   output logic          o_word_ready,
   output frame_result_t o_result,
   output logic          o_result_valid,
   input  logic          i_result_ready
);

   fifo_cnt_t count;
   word_t     sum;
   fifo_cnt_t count_next;
   word_t     sum_next;
   logic      take;
   logic      frame_done;

   // stall the input while a result waits
   assign o_word_ready = ~o_result_valid | i_result_ready;
   assign take         = i_word_valid & o_word_ready;
   assign frame_done   = take & i_word.frame_end;

   // totals including the word on the input; sum wraps mod 2^32
   assign count_next = count + 1'b1;
   assign sum_next   = sum + i_word.data;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         count <= '0;
         sum   <= '0;
      end
      else if (frame_done)
      begin
         count <= '0;
         sum   <= '0;
      end
      else if (take)
      begin
         count <= count_next;
         sum   <= sum_next;
      end
   end

   // result record
   always_ff @(posedge clk)
   begin
      if (frame_done)
      begin
         o_result.count <= count_next;
         o_result.sum   <= sum_next;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_result_valid <= 1'b0;
      end
      else if (frame_done)
      begin
         o_result_valid <= 1'b1;
      end
      else if (i_result_ready)
      begin
         o_result_valid <= 1'b0;
      end
   end

   // a frame always holds at least one word
   a_count_nonzero: assert property (@(posedge clk) disable iff (reset || i_clear)
      o_result_valid |-> o_result.count != '0);

endmodule

// File: hdl/stream_top.sv
// ##############################
// stream capture top
// packer, block RAM FIFO, checksum
// ##############################

`timescale 1ns/10ps

`include "stream_defs.svh"

module stream_top
   import stream_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          i_clear,
   input  sample_beat_t  i_sample,
   input  logic          i_sample_valid,
   output logic          o_sample_ready,
   output frame_result_t o_result,
   output logic          o_result_valid,
   input  logic          i_result_ready,
   output fifo_cnt_t     o_space,
   output fifo_cnt_t     o_occupied
);

   // packer to FIFO
   word_beat_t pack_word;
   logic       pack_valid;
   logic       pack_ready;

   // FIFO to checksum
   word_beat_t fifo_word;
   logic       fifo_valid;
   logic       fifo_ready;

   sample_packer packer (
      .clk            (clk),
      .reset          (reset),
      .i_clear        (i_clear),
      .i_sample       (i_sample),
      .i_sample_valid (i_sample_valid),
      .o_sample_ready (o_sample_ready),
      .o_word         (pack_word),
      .o_word_valid   (pack_valid),
      .i_word_ready   (pack_ready)
   );

   axi_fifo_bram #(
      .WIDTH (`WORD_W + 1),
      .SIZE  (`FIFO_AW)
   ) fifo (
      .clk        (clk),
      .reset      (reset),
      .i_clear    (i_clear),
      .i_data     (pack_word),
      .i_valid    (pack_valid),
      .o_ready    (pack_ready),
      .o_data     (fifo_word),
      .o_valid    (fifo_valid),
      .i_ready    (fifo_ready),
      .o_space    (o_space),
      .o_occupied (o_occupied)
   );

   frame_checksum checksum (
      .clk            (clk),
      .reset          (reset),
      .i_clear        (i_clear),
      .i_word         (fifo_word),
      .i_word_valid   (fifo_valid),
      .o_word_ready   (fifo_ready),
      .o_result       (o_result),
      .o_result_valid (o_result_valid),
      .i_result_ready (i_result_ready)
   );

endmodule

// File: bench/tb_clock.sv
// ##############################
// testbench clock and reset
// 8 ns clock, reset for 5 cycles
// ##############################

`timescale 1ns/10ps

module tb_clock
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

   always #4 clk = ~clk;

endmodule

// File: bench/tb_stream_top.sv
// ##############################
// stream capture testbench
// random frames against a reference model
// ##############################

`timescale 1ns/10ps

`include "stream_defs.svh"

module tb_stream_top
   import stream_pkg::*;
;

   localparam int LINES           = 2 ** `FIFO_AW;
   localparam int MAX_SAMPLES     = 4200;
   localparam int HOLD_CYCLES     = 3000;
   localparam int WATCHDOG_CYCLES = MAX_SAMPLES * 40 + HOLD_CYCLES + 2000;

   logic          clk;
   logic          reset;
   logic          i_clear;
   sample_beat_t  i_sample;
   logic          i_sample_valid;
   logic          o_sample_ready;
   frame_result_t o_result;
   logic          o_result_valid;
   logic          i_result_ready;
   fifo_cnt_t     o_space;
   fifo_cnt_t     o_occupied;

   // reference model state
   frame_result_t exp_q[$];
   frame_result_t result_expected;
   int            result_pending;
   logic          result_taken;
   logic [31:0]   lcg_state = 32'hd93a_0637;
   int            sample_total;
   string         test_name;

   // stimulus flags
   logic hold_results;
   logic check_idle;
   logic stall_done;
   logic saw_backpressure;

   tb_clock clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   stream_top uut (
      .clk            (clk),
      .reset          (reset),
      .i_clear        (i_clear),
      .i_sample       (i_sample),
      .i_sample_valid (i_sample_valid),
      .o_sample_ready (o_sample_ready),
      .o_result       (o_result),
      .o_result_valid (o_result_valid),
      .i_result_ready (i_result_ready),
      .o_space        (o_space),
      .o_occupied     (o_occupied)
   );

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {8'h00, lcg_state[31:8]};
   endfunction

   // low sample first, odd tail padded with zero, sum wraps
   function automatic frame_result_t model_result(input sample_t samples[$]);
      frame_result_t r;
      word_t         w;
      int            i;
      r.count = fifo_cnt_t'((samples.size() + 1) / 2);
      r.sum   = '0;
      for (i = 0; i < samples.size(); i += 2)
      begin
         w = {{`SAMPLE_W{1'b0}}, samples[i]};
         if (i + 1 < samples.size())
         begin
            w[`WORD_W-1:`SAMPLE_W] = samples[i+1];
         end
         r.sum = r.sum + w;
      end
      return r;
   endfunction

   task automatic stop_on_mismatch(input string check, input logic [63:0] expected,
                                   input logic [63:0] actual);
      $display("ERROR %s: expected %h, actual %h", check, expected, actual);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic stop_on_failure(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic refresh_head();
      result_pending = exp_q.size();
      if (exp_q.size() != 0)
      begin
         result_expected = exp_q[0];
      end
      else
      begin
         result_expected = '0;
      end
   endtask

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send_sample(input sample_beat_t beat);
      logic accepted;
      accepted = 1'b0;
      while (lcg_next() % 4 == 0)
      begin
         i_sample_valid = 1'b0;
         @(negedge clk);
      end
      i_sample       = beat;
      i_sample_valid = 1'b1;
      while (!accepted)
      begin
         accepted = o_sample_ready;
         @(negedge clk);
      end
      i_sample_valid = 1'b0;
   endtask

   task automatic send_frame(input int len, input logic complete);
      sample_t      samples[$];
      sample_beat_t beat;
      int           i;
      for (i = 0; i < len; i++)
      begin
         samples.push_back(sample_t'(lcg_next()));
      end
      if (complete)
      begin
         exp_q.push_back(model_result(samples));
         refresh_head();
      end
      for (i = 0; i < len; i++)
      begin
         beat.data      = samples[i];
         beat.frame_end = complete && (i == len - 1);
         send_sample(beat);
      end
      sample_total += len;
   endtask

   task automatic send_random_frames(input int frames);
      int n;
      for (n = 0; n < frames; n++)
      begin
         send_frame(1 + lcg_next() % 40, 1'b1);
      end
   endtask

   task automatic wait_drain();
      while (result_pending != 0)
      begin
         @(negedge clk);
      end
      @(negedge clk);
   endtask

   task automatic pulse_idle_check();
      check_idle = 1'b1;
      @(negedge clk);
      check_idle = 1'b0;
   endtask

   // result side: retire the transfer of the last edge, then pick a new ready
   always @(negedge clk)
   begin
      if (result_taken && exp_q.size() != 0)
      begin
         void'(exp_q.pop_front());
         refresh_head();
      end
      if (hold_results || reset)
      begin
         i_result_ready = 1'b0;
      end
      else
      begin
         i_result_ready = (lcg_next() % 4) != 0;
      end
      result_taken = o_result_valid && i_result_ready;
      if (hold_results && !o_sample_ready)
      begin
         saw_backpressure = 1'b1;
      end
   end

   a_frame_result: assert property (@(posedge clk) disable iff (reset)
      o_result_valid && i_result_ready |-> o_result == result_expected)
      else stop_on_mismatch(test_name, 64'($sampled(result_expected)), 64'($sampled(o_result)));

   a_result_order: assert property (@(posedge clk) disable iff (reset)
      o_result_valid && i_result_ready |-> result_pending != 0)
      else stop_on_failure({test_name, ": a result arrived with no frame outstanding"});

   a_idle: assert property (@(posedge clk) disable iff (reset)
      check_idle |-> {o_result_valid, o_occupied, o_space} == {1'b0, 16'd0, 16'(LINES)})
      else stop_on_mismatch(test_name, {31'd0, 1'b0, 16'd0, 16'(LINES)},
                            64'($sampled({o_result_valid, o_occupied, o_space})));

   // space plus occupied stays within the RAM
   a_counter_sum: assert property (@(posedge clk) disable iff (reset)
      ({1'b0, o_space} + {1'b0, o_occupied}) <= 17'(LINES))
      else stop_on_mismatch("drain_counters", 64'(LINES),
                            64'($sampled({1'b0, o_space} + {1'b0, o_occupied})));

   a_backpressure: assert property (@(posedge clk)
      stall_done |-> saw_backpressure)
      else stop_on_failure({test_name, ": sample input never stalled while results were held"});

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_on_failure("timeout: the frames were not all drained in time");
   end

   initial
   begin
      i_clear          = 1'b0;
      i_sample         = '0;
      i_sample_valid   = 1'b0;
      i_result_ready   = 1'b0;
      result_taken     = 1'b0;
      hold_results     = 1'b0;
      check_idle       = 1'b0;
      stall_done       = 1'b0;
      saw_backpressure = 1'b0;
      sample_total     = 0;
      refresh_head();

      test_name = "reset_idle";
      @(negedge reset);
      pulse_idle_check();

      test_name = "frame_results";
      send_random_frames(60);
      wait_drain();
      test_name = "drain_counters";
      pulse_idle_check();

      // hold results until the FIFO fills and stalls the input
      test_name    = "backpressure_fill";
      hold_results = 1'b1;
      repeat (2) @(negedge clk);
      fork
         begin
            while (sample_total < 1200 + 2400)
            begin
               send_frame(1 + lcg_next() % 40, 1'b1);
            end
         end
         begin
            repeat (HOLD_CYCLES) @(negedge clk);
            stall_done = 1'b1;
            @(negedge clk);
            stall_done   = 1'b0;
            hold_results = 1'b0;
         end
      join
      wait_drain();
      test_name = "drain_counters";
      pulse_idle_check();

      // clear with whole frames buffered and a half-sent frame
      test_name    = "clear_flush";
      hold_results = 1'b1;
      repeat (2) @(negedge clk);
      send_random_frames(3);
      send_frame(7, 1'b0);
      i_clear = 1'b1;
      @(negedge clk);
      i_clear = 1'b0;
      exp_q.delete();
      refresh_head();
      pulse_idle_check();
      hold_results = 1'b0;
      send_random_frames(10);
      wait_drain();
      test_name = "drain_counters";
      pulse_idle_check();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/dpram.sv
hdl/axi_fifo_bram.sv
hdl/sample_packer.sv
hdl/frame_checksum.sv
hdl/stream_top.sv
bench/tb_clock.sv
bench/tb_stream_top.sv
